//--- verilog/synth_pkg.sv
`default_nettype none

package synth_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and timing constants
	//////////////////////////////////////////////////////////////////////

	// Sample ticks per beat, short for simulation
	localparam int unsigned BEAT_TICKS = 6;

	// Phase accumulator width
	localparam int unsigned PHASE_W = 16;
	// Note length in beats
	localparam int unsigned BEATS_W = 4;
	// Signed output sample
	localparam int unsigned SAMPLE_W = 12;
	// Unsigned volume
	localparam int unsigned VOL_W = 8;
	// Semitone index and octave fields
	localparam int unsigned PITCH_W = 4;
	localparam int unsigned OCT_W = 3;

	// Volume after reset, half scale
	localparam logic [VOL_W-1:0] VOL_INIT = 8'd128;

	// Semitones per octave
	localparam int unsigned SEMITONES = 12;

	// Octave 0 phase steps, C up to B
	// Largest entry shifted by 7 still fits in PHASE_W
	localparam logic [PHASE_W-1:0] NOTE_STEP [SEMITONES] = '{
		16'd128,
		16'd136,
		16'd144,
		16'd152,
		16'd161,
		16'd171,
		16'd181,
		16'd192,
		16'd203,
		16'd215,
		16'd228,
		16'd241
	};

	//////////////////////////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_NOTE   = 2'd0,
		OP_REST   = 2'd1,
		OP_STOP   = 2'd2,
		OP_VOLUME = 2'd3
	} synth_op_e;

	typedef enum logic [1:0] {
		V_IDLE = 2'd0,
		V_PLAY = 2'd1,
		V_REST = 2'd2
	} voice_state_e;

	//////////////////////////////////////////////////////////////////////
	// Command words
	//////////////////////////////////////////////////////////////////////

	// From the controller, 21 bits
	typedef struct packed {
		synth_op_e          op;
		logic [PITCH_W-1:0] pitch;
		logic [OCT_W-1:0]   octave;
		logic [BEATS_W-1:0] beats;
		logic [VOL_W-1:0]   volume;
	} synth_cmd_t;

	// After decode, 30 bits
	typedef struct packed {
		synth_op_e          op;
		logic [PHASE_W-1:0] step;
		logic [BEATS_W-1:0] beats;
		logic [VOL_W-1:0]   volume;
	} voice_cmd_t;

endpackage

`default_nettype wire

//--- verilog/beat_divider.sv
`default_nettype none

module beat_divider
	import synth_pkg::*;
#(
	parameter int unsigned COUNT_TO = BEAT_TICKS
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  sample_tick,
	output logic beat
);

	// Counter width, at least one bit
	localparam int unsigned CNT_W = (COUNT_TO > 1) ? $clog2(COUNT_TO) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(COUNT_TO - 1);

	logic [CNT_W-1:0] count;
	logic             at_zero;

	// Beat fires on the tick that finds the counter at zero
	assign at_zero = (count == '0);

	//////////////////////////////////////////////////////////////////////
	// Tick counter, wraps after COUNT_TO ticks
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (sample_tick) begin
			if (count == CNT_LAST)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

	// One-cycle beat, a cycle behind its tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			beat <= 1'b0;
		else
			beat <= sample_tick & at_zero;
	end

endmodule

`default_nettype wire

//--- verilog/note_decoder.sv
`default_nettype none

module note_decoder
	import synth_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        cmd_valid,
	input  synth_cmd_t cmd,
	output logic       dec_valid,
	output voice_cmd_t dec
);

	logic [PITCH_W-1:0] semitone;
	logic [PHASE_W-1:0] base_step;
	logic [PHASE_W-1:0] oct_step;
	logic [BEATS_W-1:0] beats_fixed;

	//////////////////////////////////////////////////////////////////////
	// Pitch to phase step
	//////////////////////////////////////////////////////////////////////

	// Pitch 12..15 wraps to 0..3
	always_comb begin
		if (cmd.pitch >= PITCH_W'(SEMITONES))
			semitone = cmd.pitch - PITCH_W'(SEMITONES);
		else
			semitone = cmd.pitch;
	end

	// Octave 0 table lookup
	assign base_step = NOTE_STEP[semitone];

	// Each octave doubles the step
	assign oct_step = base_step << cmd.octave;

	// Zero length plays as one beat
	assign beats_fixed = (cmd.beats == '0) ? BEATS_W'(1) : cmd.beats;

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	// Strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else
			dec_valid <= cmd_valid;
	end

	// Decoded word, loaded with the strobe
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			dec.op     <= cmd.op;
			dec.step   <= oct_step;
			dec.beats  <= beats_fixed;
			dec.volume <= cmd.volume;
		end
	end

endmodule

`default_nettype wire

//--- verilog/voice_engine.sv
`default_nettype none

module voice_engine
	import synth_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n,
	input  wire              dec_valid,
	input  voice_cmd_t       dec,
	input  wire              beat,
	input  wire              sample_tick,
	output logic             advanced,
	output logic             phase_msb,
	output logic             sounding,
	output logic [VOL_W-1:0] volume,
	output logic             note_done
);

	voice_state_e       state;
	logic [PHASE_W-1:0] phase;
	logic [PHASE_W-1:0] step;
	logic [BEATS_W-1:0] beats_left;

	// Only a playing note makes sound
	assign sounding  = (state == V_PLAY);
	assign phase_msb = phase[PHASE_W-1];

	//////////////////////////////////////////////////////////////////////
	// Play state, phase, beat count, volume
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= V_IDLE;
			phase      <= '0;
			beats_left <= '0;
			volume     <= VOL_INIT;
			advanced   <= 1'b0;
			note_done  <= 1'b0;
		end else begin
			// Sample output follows every tick
			advanced  <= sample_tick;
			note_done <= 1'b0;

			// Phase moves only while playing
			if (sample_tick && state == V_PLAY)
				phase <= phase + step;

			if (dec_valid) begin
				// New command replaces whatever runs and drops the beat
				case (dec.op)
					OP_NOTE: begin
						state      <= V_PLAY;
						beats_left <= dec.beats;
						// Restart overrides a same-cycle advance
						phase      <= '0;
					end
					OP_REST: begin
						state      <= V_REST;
						beats_left <= dec.beats;
					end
					OP_STOP: begin
						// Silent stop without a done pulse
						state      <= V_IDLE;
						beats_left <= '0;
					end
					OP_VOLUME: begin
						volume <= dec.volume;
					end
				endcase
			end else if (beat && state != V_IDLE) begin
				// Last beat ends the note or rest
				if (beats_left <= BEATS_W'(1)) begin
					state      <= V_IDLE;
					beats_left <= '0;
					note_done  <= 1'b1;
				end else begin
					beats_left <= beats_left - 1'b1;
				end
			end
		end
	end

	// Step of the current note
	always_ff @(posedge clk) begin
		if (dec_valid && dec.op == OP_NOTE)
			step <= dec.step;
	end

endmodule

`default_nettype wire

//--- verilog/sample_output.sv
`default_nettype none

module sample_output
	import synth_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       advanced,
	input  wire                       phase_msb,
	input  wire                       sounding,
	input  wire        [VOL_W-1:0]    volume,
	output logic signed [SAMPLE_W-1:0] sample,
	output logic                      sample_valid
);

	logic signed [SAMPLE_W-1:0] magnitude;
	logic signed [SAMPLE_W-1:0] next_sample;

	// Volume zero-extended, always positive
	assign magnitude = signed'({{(SAMPLE_W-VOL_W){1'b0}}, volume});

	//////////////////////////////////////////////////////////////////////
	// Square wave level
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		if (!sounding)
			next_sample = '0;
		else if (phase_msb)
			next_sample = -magnitude;
		else
			next_sample = magnitude;
	end

	// Valid strobe, one per advance
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sample_valid <= 1'b0;
		else
			sample_valid <= advanced;
	end

	// Sample value held between strobes
	always_ff @(posedge clk) begin
		if (advanced)
			sample <= next_sample;
	end

endmodule

`default_nettype wire

//--- verilog/synth_top.sv
`default_nettype none

module synth_top
	import synth_pkg::*;
(
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        cmd_valid,
	input  synth_cmd_t                 cmd,
	input  wire                        sample_tick,
	output logic signed [SAMPLE_W-1:0] sample,
	output logic                       sample_valid,
	output logic                       note_done
);

	// Decode to engine
	logic       dec_valid;
	voice_cmd_t dec;

	// Beat pulse
	logic beat;

	// Engine to sample output
	logic             advanced;
	logic             phase_msb;
	logic             sounding;
	logic [VOL_W-1:0] volume;

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////
	note_decoder i_note_decoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.dec_valid (dec_valid),
		.dec       (dec)
	);

	beat_divider #(
		.COUNT_TO (BEAT_TICKS)
	) i_beat_divider (
		.clk         (clk),
		.rst_n       (rst_n),
		.sample_tick (sample_tick),
		.beat        (beat)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute and result
	//////////////////////////////////////////////////////////////////////
	voice_engine i_voice_engine (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec_valid   (dec_valid),
		.dec         (dec),
		.beat        (beat),
		.sample_tick (sample_tick),
		.advanced    (advanced),
		.phase_msb   (phase_msb),
		.sounding    (sounding),
		.volume      (volume),
		.note_done   (note_done)
	);

	sample_output i_sample_output (
		.clk          (clk),
		.rst_n        (rst_n),
		.advanced     (advanced),
		.phase_msb    (phase_msb),
		.sounding     (sounding),
		.volume       (volume),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free-running clock
	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// Reset low for the first cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/synth_checker.sv
`default_nettype none

module synth_checker
	import synth_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       cmd_valid,
	input  synth_cmd_t                cmd,
	input  wire                       sample_tick,
	input  wire signed [SAMPLE_W-1:0] sample,
	input  wire                       sample_valid,
	input  wire                       note_done,
	output int                        sample_errors,
	output int                        done_errors
);
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////////////////////////////////////////////
	// Reference model state
	//////////////////////////////////////////////////////////////////////
	voice_state_e       m_state;
	logic [PHASE_W-1:0] m_phase;
	logic [PHASE_W-1:0] m_step;
	int                 m_beats;
	int                 m_volume;
	// Ticks seen modulo the beat length
	int                 m_ticks;
	longint             cyc;

	// Outstanding sample and done expectations
	logic   s_pend;
	longint s_due;
	int     s_value;
	string  s_name;
	logic   d_pend;
	longint d_due;

	initial begin
		sample_errors = 0;
		done_errors   = 0;
	end

	// Octave 0 semitone step doubled once per octave
	function automatic logic [PHASE_W-1:0] step_for(input logic [PITCH_W-1:0] pitch,
		input logic [OCT_W-1:0] octave);
		int                 semi;
		logic [PHASE_W-1:0] base;
		semi = int'(pitch) % SEMITONES;
		base = NOTE_STEP[semi];
		return base << octave;
	endfunction

	task automatic clear_model();
		m_state  = V_IDLE;
		m_phase  = '0;
		m_step   = '0;
		m_beats  = 0;
		m_volume = 128;
		m_ticks  = 0;
		cyc      = 0;
		s_pend   = 1'b0;
		d_pend   = 1'b0;
	endtask

	// Compare what the DUT shows this cycle against the due expectations
	task automatic check_outputs();
		logic done_exp;
		if (sample_valid && s_pend && s_due == cyc) begin
			if ($signed(sample) != s_value) begin
				$display("FAIL %s: expected %0d actual %0d", s_name, s_value, $signed(sample));
				sample_errors++;
			end
		end else if (sample_valid) begin
			$display("sample_valid came at cycle %0d with no sample_tick two cycles before", cyc);
			sample_errors++;
		end else if (s_pend && s_due == cyc) begin
			$display("FAIL sample_timing: expected %0d actual %0d", 1, 0);
			sample_errors++;
		end
		if (s_pend && s_due <= cyc)
			s_pend = 1'b0;

		// note_done is expected only where a beat ends a note or rest
		done_exp = d_pend && d_due == cyc;
		if (note_done != done_exp) begin
			$display("FAIL note_done: expected %0d actual %0d", done_exp, note_done);
			done_errors++;
		end
		if (d_pend && d_due <= cyc)
			d_pend = 1'b0;
	endtask

	// New command replaces the running one
	task automatic apply_command(input synth_cmd_t c);
		case (c.op)
			OP_NOTE: begin
				m_state = V_PLAY;
				m_beats = (c.beats == 0) ? 1 : int'(c.beats);
				m_step  = step_for(c.pitch, c.octave);
				m_phase = '0;
			end
			OP_REST: begin
				m_state = V_REST;
				m_beats = (c.beats == 0) ? 1 : int'(c.beats);
			end
			OP_STOP: begin
				m_state = V_IDLE;
				m_beats = 0;
			end
			default: m_volume = int'(c.volume);
		endcase
	endtask

	// Phase step and expected sample come before the beat
	task automatic apply_tick();
		int value;
		if (m_state == V_PLAY)
			m_phase = m_phase + m_step;
		if (m_state != V_PLAY)
			value = 0;
		else if (m_phase[PHASE_W-1])
			value = -m_volume;
		else
			value = m_volume;
		s_pend  = 1'b1;
		s_due   = cyc + 2;
		s_value = value;
		case (m_state)
			V_PLAY:  s_name = "note_sample";
			V_REST:  s_name = "rest_sample";
			default: s_name = "idle_sample";
		endcase

		// Beat on the tick that finds the count at zero
		if (m_ticks == 0 && m_state != V_IDLE) begin
			if (m_beats <= 1) begin
				m_state = V_IDLE;
				m_beats = 0;
				d_pend  = 1'b1;
				d_due   = cyc + 2;
			end else begin
				m_beats--;
			end
		end
		m_ticks = (m_ticks + 1) % BEAT_TICKS;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Per-cycle model step
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (!rst_n) begin
			clear_model();
		end else begin
			cyc++;
			check_outputs();
			if (cmd_valid)
				apply_command(cmd);
			if (sample_tick)
				apply_tick();
		end
	end

endmodule

`default_nettype wire

//--- sim/synth_tb.sv
`default_nettype none

module synth_tb
	import synth_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CMDS       = 200;
	localparam int CHANCE         = 3;
	localparam int SLOT_CYCLES    = 8;
	localparam int CMD_OFFSET     = 4;
	localparam int DRAIN_SLOTS    = 4;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * CHANCE * SLOT_CYCLES + 500;
	localparam logic [31:0] SEED  = 32'd92;

	logic                       clk;
	logic                       rst_n;
	logic                       cmd_valid;
	synth_cmd_t                 cmd;
	logic                       sample_tick;
	logic signed [SAMPLE_W-1:0] sample;
	logic                       sample_valid;
	logic                       note_done;
	int                         sample_errors;
	int                         done_errors;
	logic [31:0]                rand_state;
	int                         cycles = 0;

	tb_clock i_tb_clock (.clk(clk), .rst_n(rst_n));

	synth_top i_synth_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.sample_tick  (sample_tick),
		.sample       (sample),
		.sample_valid (sample_valid),
		.note_done    (note_done)
	);

	synth_checker i_synth_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.sample_tick   (sample_tick),
		.sample        (sample),
		.sample_valid  (sample_valid),
		.note_done     (note_done),
		.sample_errors (sample_errors),
		.done_errors   (done_errors)
	);

	//////////////////////////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
	endfunction

	// Upper bits only, the low ones cycle too fast
	task automatic draw(output logic [14:0] v);
		rand_state = lcg_next(rand_state);
		v = rand_state[30:16];
	endtask

	task automatic make_cmd(output synth_cmd_t c);
		logic [14:0] r;
		draw(r);
		c.op = synth_op_e'(r[1:0]);
		draw(r);
		c.pitch = r[3:0];
		draw(r);
		c.octave = r[2:0];
		// Mostly short lengths so notes end between commands
		draw(r);
		c.beats = (r[3:2] != 2'b00) ? {2'b00, r[1:0]} : r[7:4];
		draw(r);
		c.volume = r[7:0];
	endtask

	// One tick, then maybe a command CMD_OFFSET cycles later
	task automatic play_slot(input logic with_cmd);
		sample_tick = 1'b1;
		@(negedge clk);
		sample_tick = 1'b0;
		repeat (CMD_OFFSET - 1) @(negedge clk);
		if (with_cmd) begin
			make_cmd(cmd);
			cmd_valid = 1'b1;
			@(negedge clk);
			cmd_valid = 1'b0;
			repeat (SLOT_CYCLES - CMD_OFFSET - 1) @(negedge clk);
		end else begin
			repeat (SLOT_CYCLES - CMD_OFFSET) @(negedge clk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and closing report
	//////////////////////////////////////////////////////////////////////
	initial begin
		int          slot;
		int          sent;
		logic [14:0] r;
		cmd_valid   = 1'b0;
		cmd         = '0;
		sample_tick = 1'b0;
		rand_state  = SEED;
		slot        = 0;
		sent        = 0;
		wait (rst_n === 1'b1);
		@(negedge clk);
		while (sent < NUM_CMDS) begin
			draw(r);
			// Forced once the slot budget would run short
			if (r % CHANCE == 0 || NUM_CMDS * CHANCE - slot <= NUM_CMDS - sent) begin
				play_slot(1'b1);
				sent++;
			end else begin
				play_slot(1'b0);
			end
			slot++;
		end
		repeat (DRAIN_SLOTS) play_slot(1'b0);
		repeat (4) @(negedge clk);
		$display("Errors: sample %0d, note_done %0d, total %0d",
			sample_errors, done_errors, sample_errors + done_errors);
		if (sample_errors + done_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Hard limit on run length
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- project.f
verilog/synth_pkg.sv
verilog/beat_divider.sv
verilog/note_decoder.sv
verilog/voice_engine.sv
verilog/sample_output.sv
verilog/synth_top.sv
sim/tb_clock.sv
sim/synth_checker.sv
sim/synth_tb.sv

//--- Bender.yml
package:
  name: synth

sources:
  - verilog/synth_pkg.sv
  - verilog/beat_divider.sv
  - verilog/note_decoder.sv
  - verilog/voice_engine.sv
  - verilog/sample_output.sv
  - verilog/synth_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/synth_checker.sv
      - sim/synth_tb.sv
